/* verilog/mandel_pkg.sv */
// shared sizes, start view and types for the Mandelbrot renderer
// fixed point is signed Q4.21; framebuffer is 32x18, so pan and zoom offsets suit that size
// step_init is also the coarsest step the navigation accepts

package mandel_pkg;

    // fixed point
    localparam int fp_width = 25;                  // total bits incl sign
    localparam int fp_int   = 4;                   // integer bits
    localparam int fp_frac  = fp_width - fp_int;   // 21 fraction bits

    typedef logic signed [fp_width-1:0] fp_t;

    // escape bound of 4.0, one bit wider so x^2 + y^2 cannot wrap
    localparam logic signed [fp_width:0] escape_limit = 26'sd8388608;

    // iteration
    localparam int iter_max = 63;                  // count limit, 0 means in the set
    localparam int cidx_w   = 6;

    typedef logic [cidx_w-1:0] cidx_t;

    // framebuffer geometry
    localparam int fb_width  = 32;
    localparam int fb_height = 18;
    localparam int fb_pixels = fb_width * fb_height;  // 576
    localparam int fb_addrw  = 10;

    typedef logic [fb_addrw-1:0] fb_addr_t;
    typedef logic [5:0]          coord_t;          // pixel x or y

    // start view
    localparam fp_t x_start_init = -25'sd7340032;  // -3.5
    localparam fp_t y_start_init = -25'sd2359296;  // -1.125
    localparam fp_t step_init    = 25'sd262144;    // 1/8, also max step

    // top-left point and pixel spacing
    typedef struct packed {
        fp_t x_start;
        fp_t y_start;
        fp_t step;
    } view_t;

    // one rendered pixel
    typedef struct packed {
        coord_t x;
        coord_t y;
        cidx_t  cidx;
    } fb_wr_t;

    // what btn_up / btn_dn act on
    typedef enum logic [1:0] {
        nav_horizontal,
        nav_vertical,
        nav_zoom
    } nav_mode_t;

    // iteration engine phases
    typedef enum logic [1:0] {
        it_idle,
        it_square,
        it_update
    } iter_state_t;

endpackage

/* verilog/view_control.sv */
// navigation: mode FSM, proposed view, step limit check and render start
// buttons are clean one-cycle strobes; they are dropped while a change or render is pending
// up wins when up and down arrive together

`timescale 1ns/1ps

module view_control import mandel_pkg::*; (
    input  logic      clk_sys,
    input  logic      rst_sys,
    input  logic      btn_mode,   // next nav mode
    input  logic      btn_up,     // left / up / zoom out
    input  logic      btn_dn,     // right / down / zoom in
    input  logic      busy,       // renderer running
    output view_t     view,       // committed view
    output logic      start,      // one-cycle render start
    output nav_mode_t nav_mode
);

    view_t view_p;           // proposed view
    logic  changed;          // proposal waiting for commit
    logic  render_required;  // render owed after reset
    logic  accept;           // buttons may act this cycle
    logic  step_ok;          // proposal within zoom limits
    fp_t   s;                // current step, shorthand

    always_comb begin
        s       = view.step;
        accept  = !changed && !busy && !start && !render_required;
        step_ok = (view_p.step != '0) && (view_p.step <= step_init);
    end

    always_ff @(posedge clk_sys) begin
        view_p <= view;  // no change unless a button acts
        start  <= 1'b0;

        if (accept) begin
            case (nav_mode)
                nav_horizontal: begin
                    if (btn_up) begin
                        view_p.x_start <= view.x_start - (s <<< 2);  // left by 4s
                        changed        <= 1'b1;
                    end else if (btn_dn) begin
                        view_p.x_start <= view.x_start + (s <<< 2);  // right by 4s
                        changed        <= 1'b1;
                    end
                    if (btn_mode) nav_mode <= nav_vertical;
                end
                nav_vertical: begin
                    if (btn_up) begin
                        view_p.y_start <= view.y_start - (s <<< 2);
                        changed        <= 1'b1;
                    end else if (btn_dn) begin
                        view_p.y_start <= view.y_start + (s <<< 2);
                        changed        <= 1'b1;
                    end
                    if (btn_mode) nav_mode <= nav_zoom;
                end
                nav_zoom: begin
                    if (btn_up) begin  // zoom out about the centre
                        view_p.x_start <= view.x_start - (s <<< 4);        // -16s
                        view_p.y_start <= view.y_start - ((s <<< 3) + s);  // -9s
                        view_p.step    <= s <<< 1;
                        changed        <= 1'b1;
                    end else if (btn_dn) begin  // zoom in
                        view_p.x_start <= view.x_start + (s <<< 3);               // +8s
                        view_p.y_start <= view.y_start + ((s <<< 2) + (s >>> 1)); // +4.5s
                        view_p.step    <= s >>> 1;
                        changed        <= 1'b1;
                    end
                    if (btn_mode) nav_mode <= nav_horizontal;
                end
                default: nav_mode <= nav_horizontal;
            endcase
        end

        // commit one cycle after the proposal, start the cycle after that
        if (changed && !busy) begin
            changed <= 1'b0;
            if (step_ok) begin  // too far in or out, drop it
                view  <= view_p;
                start <= 1'b1;
            end
        end else if (render_required) begin
            start           <= 1'b1;  // first frame after reset
            render_required <= 1'b0;
        end

        if (rst_sys) begin
            nav_mode        <= nav_horizontal;
            view.x_start    <= x_start_init;
            view.y_start    <= y_start_init;
            view.step       <= step_init;
            changed         <= 1'b0;
            render_required <= 1'b1;
            start           <= 1'b0;
        end
    end

endmodule

/* verilog/mandel_iter.sv */
// escape-time iteration of z = z^2 + c from z = 0, two cycles per iteration
// products are truncated to Q4.21 and may wrap for large z
// it_count is updates done before |z|^2 > 4, or 0 once iter_max is reached

`timescale 1ns/1ps

module mandel_iter import mandel_pkg::*; (
    input  logic  clk_sys,
    input  logic  rst_sys,
    input  logic  it_start,  // latch c and begin
    input  fp_t   cx,        // real part of c
    input  fp_t   cy,        // imaginary part of c
    output logic  it_done,   // one-cycle pulse, it_count valid
    output cidx_t it_count
);

    iter_state_t state;

    fp_t   cx_r, cy_r;  // latched point
    fp_t   x, y;        // z
    fp_t   x2, y2, xy;  // registered products
    cidx_t cnt;         // updates so far

    logic signed [2*fp_width-1:0] px2, py2, pxy;  // full products
    logic signed [fp_width:0]     mag;            // x^2 + y^2, one bit wider

    always_comb begin
        px2 = x * x;
        py2 = y * y;
        pxy = x * y;
        mag = x2 + y2;
    end

    always_ff @(posedge clk_sys) begin
        it_done <= 1'b0;

        case (state)
            it_idle: begin
                if (it_start) begin
                    cx_r  <= cx;
                    cy_r  <= cy;
                    x     <= '0;  // z starts at 0
                    y     <= '0;
                    cnt   <= '0;
                    state <= it_square;
                end
            end
            it_square: begin  // drop fraction bits back to Q4.21
                x2    <= fp_t'(px2 >>> fp_frac);
                y2    <= fp_t'(py2 >>> fp_frac);
                xy    <= fp_t'(pxy >>> fp_frac);
                state <= it_update;
            end
            it_update: begin
                if (mag > escape_limit) begin  // escape test before update
                    it_count <= cnt;
                    it_done  <= 1'b1;
                    state    <= it_idle;
                end else if (cnt == cidx_t'(iter_max - 1)) begin
                    it_count <= '0;  // limit hit, in the set
                    it_done  <= 1'b1;
                    state    <= it_idle;
                end else begin
                    x     <= x2 - y2 + cx_r;
                    y     <= (xy <<< 1) + cy_r;  // 2xy + cy
                    cnt   <= cnt + 1'b1;
                    state <= it_square;
                end
            end
            default: state <= it_idle;
        endcase

        if (rst_sys) begin
            state   <= it_idle;
            it_done <= 1'b0;
        end
    end

endmodule

/* verilog/render_scan.sv */
// row-major scan of the framebuffer, one escape-time iteration per pixel
// view is latched at start; coordinates step by adding step, no multipliers
// starts ignored while busy

`timescale 1ns/1ps

module render_scan import mandel_pkg::*; (
    input  logic   clk_sys,
    input  logic   rst_sys,
    input  logic   start,       // begin a frame
    input  view_t  view,
    output fb_wr_t pix,         // pixel to write
    output logic   pix_valid,   // one cycle per pixel
    output logic   busy,        // start until frame_done
    output logic   frame_done   // one-cycle pulse
);

    typedef enum logic [2:0] {
        sc_idle,   // waiting for start
        sc_iter,   // kick the iteration engine
        sc_wait,   // wait for it_done
        sc_write,  // pix presented
        sc_last    // last write lands
    } scan_state_t;

    scan_state_t state;

    view_t  view_r;        // view of this frame
    coord_t x, y;          // pixel counters
    fp_t    cx, cy;        // running coordinate
    logic   it_start;
    logic   it_done;
    cidx_t  it_count;

    assign it_start = (state == sc_iter);

    mandel_iter i_mandel_iter (
        .clk_sys  (clk_sys),
        .rst_sys  (rst_sys),
        .it_start (it_start),
        .cx       (cx),
        .cy       (cy),
        .it_done  (it_done),
        .it_count (it_count)
    );

    always_ff @(posedge clk_sys) begin
        pix_valid  <= 1'b0;
        frame_done <= 1'b0;

        case (state)
            sc_idle: begin
                if (start) begin
                    view_r <= view;
                    x      <= '0;
                    y      <= '0;
                    cx     <= view.x_start;  // top-left pixel
                    cy     <= view.y_start;
                    busy   <= 1'b1;
                    state  <= sc_iter;
                end
            end
            sc_iter: state <= sc_wait;  // engine latches c this cycle
            sc_wait: begin
                if (it_done) begin
                    pix.x     <= x;
                    pix.y     <= y;
                    pix.cidx  <= it_count;
                    pix_valid <= 1'b1;
                    state     <= sc_write;
                end
            end
            sc_write: begin
                if (x == coord_t'(fb_width - 1)) begin
                    x  <= '0;
                    y  <= y + 1'b1;
                    cx <= view_r.x_start;  // back to left edge
                    cy <= cy + view_r.step;
                    if (y == coord_t'(fb_height - 1)) state <= sc_last;
                    else                              state <= sc_iter;
                end else begin
                    x     <= x + 1'b1;
                    cx    <= cx + view_r.step;
                    state <= sc_iter;
                end
            end
            sc_last: begin  // framebuffer write done by now
                frame_done <= 1'b1;
                busy       <= 1'b0;
                state      <= sc_idle;
            end
            default: state <= sc_idle;
        endcase

        if (rst_sys) begin
            state      <= sc_idle;
            busy       <= 1'b0;
            pix_valid  <= 1'b0;
            frame_done <= 1'b0;
        end
    end

endmodule

/* verilog/framebuffer.sv */
// colour index framebuffer, 32x18, simple dual port on clk_sys
// write lands one cycle after pix_valid; read data one cycle after rd_addr
// contents undefined until the first frame is written

`timescale 1ns/1ps

module framebuffer import mandel_pkg::*; (
    input  logic     clk_sys,
    input  fb_wr_t   pix,        // pixel from renderer
    input  logic     pix_valid,
    input  fb_addr_t rd_addr,
    output cidx_t    rd_cidx     // index at rd_addr, one cycle later
);

    cidx_t    mem [fb_pixels];

    fb_addr_t wr_addr;  // registered y * width + x
    cidx_t    wr_cidx;  // data delayed to match address
    logic     wr_en;    // pix_valid delayed to match

    // address stage
    always_ff @(posedge clk_sys) begin
        wr_addr <= fb_addr_t'(pix.y * fb_width + pix.x);
        wr_cidx <= pix.cidx;
        wr_en   <= pix_valid;
    end

    // write port
    always_ff @(posedge clk_sys) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_cidx;
        end
    end

    // read port, registered
    always_ff @(posedge clk_sys) begin
        rd_cidx <= mem[rd_addr];
    end

endmodule

/* verilog/mandel_core.sv */
// Mandelbrot renderer core: navigation, pixel scan and framebuffer
// buttons must be clean one-cycle strobes on clk_sys
// display side reads colour indices through rd_addr / rd_cidx

`timescale 1ns/1ps

module mandel_core import mandel_pkg::*; (
    input  logic      clk_sys,
    input  logic      rst_sys,
    input  logic      btn_mode,
    input  logic      btn_up,
    input  logic      btn_dn,
    input  fb_addr_t  rd_addr,
    output nav_mode_t nav_mode,
    output logic      render_busy,
    output logic      frame_done,
    output cidx_t     rd_cidx
);

    view_t  view;       // committed view
    logic   start;      // render start pulse
    fb_wr_t pix;        // rendered pixel
    logic   pix_valid;

    view_control i_view_control (
        .clk_sys  (clk_sys),
        .rst_sys  (rst_sys),
        .btn_mode (btn_mode),
        .btn_up   (btn_up),
        .btn_dn   (btn_dn),
        .busy     (render_busy),
        .view     (view),
        .start    (start),
        .nav_mode (nav_mode)
    );

    render_scan i_render_scan (
        .clk_sys    (clk_sys),
        .rst_sys    (rst_sys),
        .start      (start),
        .view       (view),
        .pix        (pix),
        .pix_valid  (pix_valid),
        .busy       (render_busy),
        .frame_done (frame_done)
    );

    framebuffer i_framebuffer (
        .clk_sys   (clk_sys),
        .pix       (pix),
        .pix_valid (pix_valid),
        .rd_addr   (rd_addr),
        .rd_cidx   (rd_cidx)
    );

endmodule

/* verification/tb_mandel_core.sv */
// testbench for mandel_core with its own model of navigation and escape count
// pixels are spot checked through rd_addr after each frame_done
// a full frame can take about 80k cycles, frame waits allow 200k

`timescale 1ns/1ps

module tb_mandel_core import mandel_pkg::*; ();

    localparam int frame_timeout = 200000;  // cycles
    localparam logic signed [fp_width:0] escape_bound = 26'sd8388608;  // 4.0 in Q4.21

    logic      clk_sys;
    logic      rst_sys;
    logic      btn_mode;
    logic      btn_up;
    logic      btn_dn;
    fb_addr_t  rd_addr;
    nav_mode_t nav_mode;
    logic      render_busy;
    logic      frame_done;
    cidx_t     rd_cidx;

    fp_t       m_x;     // model view, top-left real
    fp_t       m_y;     // top-left imaginary
    fp_t       m_step;  // pixel spacing
    nav_mode_t m_mode;
    integer    seed;

    mandel_core i_mandel_core (
        .clk_sys     (clk_sys),
        .rst_sys     (rst_sys),
        .btn_mode    (btn_mode),
        .btn_up      (btn_up),
        .btn_dn      (btn_dn),
        .rd_addr     (rd_addr),
        .nav_mode    (nav_mode),
        .render_busy (render_busy),
        .frame_done  (frame_done),
        .rd_cidx     (rd_cidx)
    );

    initial begin
        clk_sys = 1'b0;
        forever #50 clk_sys = ~clk_sys;  // 100 ns period
    end

    task automatic abort_run();
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        assert (got === exp) else begin
            $display("MISMATCH at %0t: %s expected %0d seen %0d", $time, name, exp, got);
            abort_run();
        end
    endtask

    // z = z^2 + c from z = 0, products cut back to Q4.21, sums wrap at 25 bits
    function automatic int escape_count(input fp_t cx, input fp_t cy);
        fp_t x, y, x2, y2, xy;
        logic signed [2*fp_width-1:0] p;
        logic signed [fp_width:0]     mag;
        int n;
        x = '0;
        y = '0;
        for (n = 0; n < iter_max; n++) begin  // n = updates done so far
            p   = 50'(x) * 50'(x);
            x2  = fp_t'(p >>> fp_frac);
            p   = 50'(y) * 50'(y);
            y2  = fp_t'(p >>> fp_frac);
            p   = 50'(x) * 50'(y);
            xy  = fp_t'(p >>> fp_frac);
            mag = 26'(x2) + 26'(y2);
            if (mag > escape_bound) return n;  // test before update
            x = x2 - y2 + cx;
            y = xy + xy + cy;
        end
        return 0;  // limit reached, in the set
    endfunction

    function automatic fp_t pixel_coord(input fp_t origin, input fp_t step, input int n);
        return fp_t'(origin + n * step);  // wraps like the running sum
    endfunction

    // apply one button strobe to the model, render = a committed change
    task automatic model_buttons(input logic b_mode, input logic b_up, input logic b_dn,
                                 output logic render);
        fp_t s, nx, ny, ns;
        s      = m_step;
        nx     = m_x;
        ny     = m_y;
        ns     = m_step;
        render = 1'b0;
        if (b_up || b_dn) begin
            case (m_mode)
                nav_horizontal: nx = b_up ? fp_t'(m_x - 4 * s) : fp_t'(m_x + 4 * s);
                nav_vertical:   ny = b_up ? fp_t'(m_y - 4 * s) : fp_t'(m_y + 4 * s);
                default: begin
                    if (b_up) begin  // zoom out
                        nx = fp_t'(m_x - 16 * s);
                        ny = fp_t'(m_y - 9 * s);
                        ns = fp_t'(2 * s);
                    end else begin   // zoom in
                        nx = fp_t'(m_x + 8 * s);
                        ny = fp_t'(m_y + 4 * s + s / 2);
                        ns = fp_t'(s / 2);
                    end
                end
            endcase
            render = (ns != '0) && (ns <= step_init);
            if (render) begin
                m_x    = nx;
                m_y    = ny;
                m_step = ns;
            end
        end
        if (b_mode) begin
            case (m_mode)
                nav_horizontal: m_mode = nav_vertical;
                nav_vertical:   m_mode = nav_zoom;
                default:        m_mode = nav_horizontal;
            endcase
        end
    endtask

    task automatic strobe_buttons(input logic b_mode, input logic b_up, input logic b_dn);
        @(negedge clk_sys);
        btn_mode = b_mode;
        btn_up   = b_up;
        btn_dn   = b_dn;
        @(negedge clk_sys);
        btn_mode = 1'b0;  // one-cycle strobe
        btn_up   = 1'b0;
        btn_dn   = 1'b0;
    endtask

    task automatic wait_busy_high(input int limit);
        int n;
        n = 0;
        while (render_busy !== 1'b1) begin
            assert (n < limit) else begin
                $display("timeout: render_busy did not rise within %0d cycles", limit);
                abort_run();
            end
            @(negedge clk_sys);
            n++;
        end
    endtask

    task automatic wait_frame_done(input int limit);
        int n;
        n = 0;
        while (frame_done !== 1'b1) begin
            assert (n < limit) else begin
                $display("timeout: no frame_done within %0d cycles", limit);
                abort_run();
            end
            @(negedge clk_sys);
            n++;
        end
        check_value("render_busy", 0, render_busy);  // falls with frame_done
    endtask

    task automatic expect_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk_sys);
            check_value("render_busy", 0, render_busy);
        end
    endtask

    task automatic check_pixel(input int px, input int py);
        int exp;
        @(negedge clk_sys);
        rd_addr = fb_addr_t'(py * fb_width + px);
        @(negedge clk_sys);  // registered read
        exp = escape_count(pixel_coord(m_x, m_step, px), pixel_coord(m_y, m_step, py));
        check_value($sformatf("rd_cidx(%0d,%0d)", px, py), exp, 32'(rd_cidx));
    endtask

    task automatic check_random_pixels(input int count);
        int addr;
        repeat (count) begin
            addr = int'($unsigned($random(seed)) % fb_pixels);
            check_pixel(addr % fb_width, addr / fb_width);
        end
    endtask

    task automatic press_and_check(input logic b_mode, input logic b_up, input logic b_dn);
        logic render;
        model_buttons(b_mode, b_up, b_dn, render);
        strobe_buttons(b_mode, b_up, b_dn);
        if (render) begin
            wait_busy_high(10);
            wait_frame_done(frame_timeout);
            expect_idle(20);  // exactly one render
            check_random_pixels(24);
        end else begin
            expect_idle(20);
        end
        check_value("nav_mode", m_mode, nav_mode);
    endtask

    initial begin
        logic render;
        seed     = 32'had29_7ad3;
        rst_sys  = 1'b1;
        btn_mode = 1'b0;
        btn_up   = 1'b0;
        btn_dn   = 1'b0;
        rd_addr  = '0;
        m_x      = x_start_init;
        m_y      = y_start_init;
        m_step   = step_init;
        m_mode   = nav_horizontal;

        repeat (2) begin  // reset held 2 cycles
            @(negedge clk_sys);
            check_value("render_busy", 0, render_busy);
            check_value("frame_done", 0, frame_done);
        end
        rst_sys = 1'b0;
        check_value("nav_mode", nav_horizontal, nav_mode);

        wait_busy_high(6);  // first frame needs no button
        wait_frame_done(frame_timeout);
        check_random_pixels(40);

        // in-set points read 0
        check_value("escape_count(0,0)", 0, escape_count('0, '0));
        check_value("escape_count(-1,0)", 0, escape_count(-(25'sd1 <<< fp_frac), '0));
        // z starts at 0, so one update is the earliest escape
        check_value("escape_count(-2.5,0)", 1, escape_count(-25'sd5242880, '0));
        check_pixel(28, 9);  // c = 0
        check_pixel(20, 9);  // c = -1, period two orbit
        check_pixel(8, 9);   // c = -2.5 escapes after one update

        press_and_check(1'b1, 1'b0, 1'b0);  // vertical
        press_and_check(1'b1, 1'b0, 1'b0);  // zoom
        press_and_check(1'b1, 1'b0, 1'b0);  // back to horizontal

        press_and_check(1'b0, 1'b0, 1'b1);  // pan right
        press_and_check(1'b1, 1'b0, 1'b0);
        press_and_check(1'b0, 1'b1, 1'b0);  // pan up

        press_and_check(1'b1, 1'b0, 1'b0);  // zoom mode
        press_and_check(1'b0, 1'b0, 1'b1);  // in, step 1/16
        press_and_check(1'b0, 1'b1, 1'b0);  // out, step 1/8
        press_and_check(1'b0, 1'b1, 1'b0);  // step 1/4 rejected

        // strobes while a render runs are dropped
        model_buttons(1'b0, 1'b0, 1'b1, render);
        check_value("model render", 1, render);
        strobe_buttons(1'b0, 1'b0, 1'b1);
        wait_busy_high(10);
        strobe_buttons(1'b0, 1'b1, 1'b0);
        strobe_buttons(1'b1, 1'b0, 1'b0);
        check_value("render_busy", 1, render_busy);
        check_value("nav_mode", m_mode, nav_mode);
        wait_frame_done(frame_timeout);
        expect_idle(20);
        check_random_pixels(40);
        check_value("nav_mode", m_mode, nav_mode);

        $display("all tests passed");
        $finish;
    end

endmodule

/* all.f */
verilog/mandel_pkg.sv
verilog/view_control.sv
verilog/mandel_iter.sv
verilog/render_scan.sv
verilog/framebuffer.sv
verilog/mandel_core.sv
verification/tb_mandel_core.sv

/* Makefile */
TOP = tb_mandel_core

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir obj_dir -f all.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "all tests passed"

lint:
	verilator --lint-only --timing --assert -Wall --top-module $(TOP) -f all.f

clean:
	rm -rf obj_dir
